//--- source/midi_pkg.sv
`default_nettype none

package midi_pkg;

    localparam int CLKS_PER_BIT = 320;                      // 31250 baud at 10 MHz reg_clk
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);     // bit timer width

    // upper nibble bits [6:4] of a status byte
    localparam logic [2:0] ST_NOTE_OFF = 3'd0;              // 0x8n
    localparam logic [2:0] ST_NOTE_ON  = 3'd1;              // 0x9n
    localparam logic [2:0] ST_CTRL     = 3'd3;              // 0xBn
    localparam logic [2:0] ST_PROG     = 3'd4;              // 0xCn
    localparam logic [2:0] ST_PITCH    = 3'd6;              // 0xEn
    localparam logic [2:0] ST_SYSTEM   = 3'd7;              // 0xF0 and up

    typedef struct packed {
        logic       marker;                                 // 1 for status
        logic [2:0] msg_type;
        logic [3:0] channel;                                // low nibble, sub-type for 0xFx
    } status_byte_t;

    typedef struct packed {
        logic       marker;                                 // 0 for data
        logic [6:0] value;
    } data_byte_t;

    typedef union packed {
        status_byte_t st;
        data_byte_t   dat;
    } midi_byte_u;

    typedef enum logic [2:0] {
        EV_NOTE_ON,
        EV_NOTE_OFF,
        EV_CTRL,
        EV_PROG,
        EV_PITCH
    } ev_kind_e;

    typedef struct packed {
        ev_kind_e   kind;
        logic [6:0] data1;                                  // key / ctrl nr / program / lsb
        logic [6:0] data2;                                  // velocity / value / msb
    } midi_event_t;

    typedef struct packed {
        logic [6:0]  ctrl_num;
        logic [6:0]  ctrl_val;
        logic [6:0]  prg_num;
        logic [13:0] pitch;                                 // msb:lsb bend value
    } ctrl_cmd_t;

endpackage

`default_nettype wire

//--- source/voice_pkg.sv
`default_nettype none

package voice_pkg;

    localparam int VOICES  = 8;                             // polyphony
    localparam int V_WIDTH = 3;                             // voice index bits

    typedef struct packed {
        logic [V_WIDTH-1:0] key_adr;                        // voice slot
        logic [7:0]         key_val;                        // note number
        logic [7:0]         vel_on;                         // last note-on velocity
        logic [7:0]         vel_off;                        // last release velocity
    } note_out_t;

endpackage

`default_nettype wire

//--- source/midi_uart_rx.sv
`default_nettype none

module midi_uart_rx (
    input  logic       reg_clk,
    input  logic       rst_n,
    input  logic       midi_rxd,
    output logic       rx_strobe,
    output logic [7:0] rx_byte
);
    import midi_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e            state;
    logic [1:0]           rxd_sync;                         // two-flop synchroniser
    logic                 rxd_prev;                         // for falling edge detect
    logic                 line;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_idx;
    logic                 half_tick;
    logic                 bit_tick;

    assign line      = rxd_sync[1];
    assign half_tick = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1));   // middle of start bit
    assign bit_tick  = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));       // one full bit later

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_sync  <= 2'b00;                             // line must go high before a start
            rxd_prev  <= 1'b0;
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rxd_sync  <= {rxd_sync[0], midi_rxd};
            rxd_prev  <= line;
            clk_cnt   <= clk_cnt + 1'b1;
            rx_strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rxd_prev && !line)                  // high to low, start edge
                        state <= RX_START;
                end
                RX_START: begin
                    if (half_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= line ? RX_IDLE : RX_DATA; // glitch, back to idle
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        rx_strobe <= line;                  // framing error drops the byte
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first shift in at mid-bit
    always_ff @(posedge reg_clk) begin
        if (state == RX_DATA && bit_tick)
            rx_byte <= {line, rx_byte[7:1]};
    end

endmodule

`default_nettype wire

//--- source/midi_in_select.sv
`default_nettype none

module midi_in_select (
    input  logic                 reg_clk,
    input  logic                 rst_n,
    input  logic                 uart_usb_sel,
    input  logic [2:0]           socmidi_addr,
    input  logic [7:0]           socmidi_data_in,
    input  logic                 socmidi_write,
    input  logic                 rx_strobe,
    input  logic [7:0]           rx_byte,
    output logic                 byte_strobe,
    output midi_pkg::midi_byte_u midi_byte
);

    logic cpu_wr;                                           // write to the midi data register
    logic take_uart;
    logic take_cpu;

    assign cpu_wr    = socmidi_write && (socmidi_addr == 3'd0);
    assign take_uart = uart_usb_sel && rx_strobe;
    assign take_cpu  = !uart_usb_sel && cpu_wr;             // cpu ignored in serial mode

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n)
            byte_strobe <= 1'b0;
        else
            byte_strobe <= take_uart || take_cpu;
    end

    always_ff @(posedge reg_clk) begin
        if (take_uart)
            midi_byte <= rx_byte;
        else if (take_cpu)
            midi_byte <= socmidi_data_in;
    end

endmodule

`default_nettype wire

//--- source/midi_parser.sv
`default_nettype none

module midi_parser (
    input  logic                  reg_clk,
    input  logic                  rst_n,
    input  logic [3:0]            midi_ch,
    input  logic                  byte_strobe,
    input  midi_pkg::midi_byte_u  midi_byte,
    output logic                  ev_strobe,
    output midi_pkg::midi_event_t midi_event
);
    import midi_pkg::*;

    logic        run_valid;                                 // running status present
    logic [2:0]  run_type;
    logic [3:0]  run_ch;
    logic        have_d1;                                   // first data byte stored
    logic [6:0]  data1;
    logic        data_ok;
    logic        msg_done;
    logic        kind_ok;
    midi_event_t ev_next;

    // data byte on our channel with a valid running status
    assign data_ok  = byte_strobe && !midi_byte.dat.marker && run_valid && (run_ch == midi_ch);
    assign msg_done = data_ok && (have_d1 || run_type == ST_PROG);   // prog change is 1 byte

    always_comb begin
        kind_ok       = 1'b1;
        ev_next.data1 = have_d1 ? data1 : midi_byte.dat.value;
        ev_next.data2 = have_d1 ? midi_byte.dat.value : 7'd0;
        case (run_type)
            ST_NOTE_OFF: ev_next.kind = EV_NOTE_OFF;
            ST_NOTE_ON:  ev_next.kind = (midi_byte.dat.value == 7'd0) ? EV_NOTE_OFF
                                                                      : EV_NOTE_ON;
            ST_CTRL:     ev_next.kind = EV_CTRL;
            ST_PROG:     ev_next.kind = EV_PROG;
            ST_PITCH:    ev_next.kind = EV_PITCH;
            default: begin                                  // aftertouch, pressure: no event
                ev_next.kind = EV_CTRL;
                kind_ok      = 1'b0;
            end
        endcase
    end

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            run_valid <= 1'b0;
            have_d1   <= 1'b0;
            ev_strobe <= 1'b0;
        end else begin
            ev_strobe <= msg_done && kind_ok;
            if (byte_strobe) begin
                if (midi_byte.st.marker) begin
                    if (midi_byte.st.msg_type != ST_SYSTEM) begin
                        run_valid <= 1'b1;                  // new channel status
                        have_d1   <= 1'b0;
                    end else if (!midi_byte.st.channel[3]) begin
                        run_valid <= 1'b0;                  // sysex / common cancels
                        have_d1   <= 1'b0;
                    end                                     // real-time passes through
                end else if (data_ok) begin
                    have_d1 <= !msg_done;
                end
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (byte_strobe && midi_byte.st.marker && midi_byte.st.msg_type != ST_SYSTEM) begin
            run_type <= midi_byte.st.msg_type;
            run_ch   <= midi_byte.st.channel;
        end
        if (data_ok && !msg_done)
            data1 <= midi_byte.dat.value;
        if (msg_done)
            midi_event <= ev_next;
    end

endmodule

`default_nettype wire

//--- source/note_stack.sv
`default_nettype none

module note_stack (
    input  logic                         reg_clk,
    input  logic                         rst_n,
    input  logic [voice_pkg::VOICES-1:0] voice_free,
    input  logic                         ev_strobe,
    input  midi_pkg::midi_event_t        midi_event,
    output logic                         note_on,
    output logic                         note_off,
    output voice_pkg::note_out_t         note,
    output logic [voice_pkg::VOICES-1:0] keys_on,
    output logic [voice_pkg::V_WIDTH:0]  active_keys
);
    import midi_pkg::*;
    import voice_pkg::*;

    logic [6:0]         key_tab [VOICES];                   // key held by each voice
    logic [VOICES-1:0]  avail;
    logic [VOICES-1:0]  hit;
    logic [V_WIDTH-1:0] free_idx;
    logic [V_WIDTH-1:0] hit_idx;
    logic               do_on;
    logic               do_off;
    logic [VOICES-1:0]  keys_next;
    logic [V_WIDTH:0]   keys_cnt;

    always_comb begin
        avail    = voice_free & ~keys_on;                   // free in engine and not held
        free_idx = '0;
        hit_idx  = '0;
        for (int i = VOICES - 1; i >= 0; i--) begin         // downward, lowest index wins
            hit[i] = keys_on[i] && (key_tab[i] == midi_event.data1);
            if (avail[i])
                free_idx = V_WIDTH'(i);
            if (hit[i])
                hit_idx = V_WIDTH'(i);
        end
        do_on  = ev_strobe && (midi_event.kind == EV_NOTE_ON) && !(|hit) && (|avail);
        do_off = ev_strobe && (midi_event.kind == EV_NOTE_OFF) && (|hit);
        keys_next = keys_on;
        if (do_on)
            keys_next[free_idx] = 1'b1;
        if (do_off)
            keys_next[hit_idx] = 1'b0;
        keys_cnt = '0;
        for (int i = 0; i < VOICES; i++)
            keys_cnt = keys_cnt + {{V_WIDTH{1'b0}}, keys_next[i]};
    end

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            note_on     <= 1'b0;
            note_off    <= 1'b0;
            keys_on     <= '0;
            active_keys <= '0;
        end else begin
            note_on     <= do_on;
            note_off    <= do_off;
            keys_on     <= keys_next;
            active_keys <= keys_cnt;                        // count in step with keys_on
        end
    end

    always_ff @(posedge reg_clk) begin
        if (do_on) begin
            key_tab[free_idx] <= midi_event.data1;
            note.key_adr      <= free_idx;
            note.key_val      <= {1'b0, midi_event.data1};
            note.vel_on       <= {1'b0, midi_event.data2};
        end
        if (do_off) begin
            note.key_adr <= hit_idx;
            note.key_val <= {1'b0, midi_event.data1};
            note.vel_off <= {1'b0, midi_event.data2};      // 0 for vel-0 note-on
        end
    end

endmodule

`default_nettype wire

//--- source/controller_cmd.sv
`default_nettype none

module controller_cmd (
    input  logic                  reg_clk,
    input  logic                  rst_n,
    input  logic                  ev_strobe,
    input  midi_pkg::midi_event_t midi_event,
    output logic                  ctrl_cmd,
    output logic                  prg_ch_cmd,
    output logic                  pitch_cmd,
    output midi_pkg::ctrl_cmd_t   cmd
);
    import midi_pkg::*;

    logic is_ctrl;
    logic is_prog;
    logic is_pitch;

    assign is_ctrl  = ev_strobe && (midi_event.kind == EV_CTRL);
    assign is_prog  = ev_strobe && (midi_event.kind == EV_PROG);
    assign is_pitch = ev_strobe && (midi_event.kind == EV_PITCH);

    always_ff @(posedge reg_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_cmd   <= 1'b0;
            prg_ch_cmd <= 1'b0;
            pitch_cmd  <= 1'b0;
        end else begin
            ctrl_cmd   <= is_ctrl;
            prg_ch_cmd <= is_prog;
            pitch_cmd  <= is_pitch;
        end
    end

    // each field holds until its own kind arrives again
    always_ff @(posedge reg_clk) begin
        if (is_ctrl) begin
            cmd.ctrl_num <= midi_event.data1;
            cmd.ctrl_val <= midi_event.data2;
        end
        if (is_prog)
            cmd.prg_num <= midi_event.data1;
        if (is_pitch)                                       // msb << 7 | lsb
            cmd.pitch <= (14'(midi_event.data2) << 7) | 14'(midi_event.data1);
    end

endmodule

`default_nettype wire

//--- source/synth_controller.sv
`default_nettype none

module synth_controller (
    input  logic                         reg_clk,
    input  logic                         rst_n,
    // cpu write port
    input  logic [2:0]                   socmidi_addr,
    input  logic [7:0]                   socmidi_data_in,
    input  logic                         socmidi_write,
    // serial midi
    input  logic                         midi_rxd,
    input  logic                         uart_usb_sel,      // 1 = serial, 0 = cpu
    // from synth engine
    input  logic [3:0]                   midi_ch,
    input  logic [voice_pkg::VOICES-1:0] voice_free,
    // note events
    output logic                         note_on,
    output logic                         note_off,
    output voice_pkg::note_out_t         note,
    output logic [voice_pkg::VOICES-1:0] keys_on,
    output logic [voice_pkg::V_WIDTH:0]  active_keys,
    // controller commands
    output logic                         ctrl_cmd,
    output logic                         prg_ch_cmd,
    output logic                         pitch_cmd,
    output midi_pkg::ctrl_cmd_t          cmd
);
    import midi_pkg::*;

    logic        rx_strobe;
    logic [7:0]  rx_byte;
    logic        byte_strobe;
    midi_byte_u  midi_byte;
    logic        ev_strobe;
    midi_event_t midi_event;

    midi_uart_rx u_rx (
        .reg_clk   (reg_clk),
        .rst_n     (rst_n),
        .midi_rxd  (midi_rxd),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte)
    );

    midi_in_select u_sel (
        .reg_clk         (reg_clk),
        .rst_n           (rst_n),
        .uart_usb_sel    (uart_usb_sel),
        .socmidi_addr    (socmidi_addr),
        .socmidi_data_in (socmidi_data_in),
        .socmidi_write   (socmidi_write),
        .rx_strobe       (rx_strobe),
        .rx_byte         (rx_byte),
        .byte_strobe     (byte_strobe),
        .midi_byte       (midi_byte)
    );

    midi_parser u_parser (
        .reg_clk     (reg_clk),
        .rst_n       (rst_n),
        .midi_ch     (midi_ch),
        .byte_strobe (byte_strobe),
        .midi_byte   (midi_byte),
        .ev_strobe   (ev_strobe),
        .midi_event  (midi_event)
    );

    note_stack u_notes (
        .reg_clk     (reg_clk),
        .rst_n       (rst_n),
        .voice_free  (voice_free),
        .ev_strobe   (ev_strobe),
        .midi_event  (midi_event),
        .note_on     (note_on),
        .note_off    (note_off),
        .note        (note),
        .keys_on     (keys_on),
        .active_keys (active_keys)
    );

    controller_cmd u_ctrl (
        .reg_clk    (reg_clk),
        .rst_n      (rst_n),
        .ev_strobe  (ev_strobe),
        .midi_event (midi_event),
        .ctrl_cmd   (ctrl_cmd),
        .prg_ch_cmd (prg_ch_cmd),
        .pitch_cmd  (pitch_cmd),
        .cmd        (cmd)
    );

endmodule

`default_nettype wire

//--- tests/tb_synth_controller.sv
`default_nettype none

module tb_synth_controller;
    timeunit 1ns;
    timeprecision 100ps;

    import midi_pkg::*;
    import voice_pkg::*;

    logic               reg_clk = 1'b0;
    logic               rst_n;
    logic [2:0]         socmidi_addr;
    logic [7:0]         socmidi_data_in;
    logic               socmidi_write;
    logic               midi_rxd;
    logic               uart_usb_sel;
    logic [3:0]         midi_ch;
    logic [VOICES-1:0]  voice_free;
    logic               note_on;
    logic               note_off;
    note_out_t          note;
    logic [VOICES-1:0]  keys_on;
    logic [V_WIDTH:0]   active_keys;
    logic               ctrl_cmd;
    logic               prg_ch_cmd;
    logic               pitch_cmd;
    ctrl_cmd_t          cmd;

    // reference model state
    logic               m_valid;                            // running status held
    logic [2:0]         m_type;
    logic [3:0]         m_ch;
    logic               m_cnt;                              // first data byte seen
    logic [6:0]         m_d1;
    logic [VOICES-1:0]  m_keys;
    logic [6:0]         m_tab [VOICES];

    // expected response of the current byte
    logic               exp_on, exp_off, exp_ctrl, exp_prog, exp_pitch;
    logic [V_WIDTH-1:0] exp_adr;
    logic [6:0]         exp_key, exp_vel, exp_d1, exp_d2;

    int checks = 0;
    int errors = 0;

    synth_controller dut0 (
        .reg_clk(reg_clk), .rst_n(rst_n),
        .socmidi_addr(socmidi_addr), .socmidi_data_in(socmidi_data_in),
        .socmidi_write(socmidi_write), .midi_rxd(midi_rxd), .uart_usb_sel(uart_usb_sel),
        .midi_ch(midi_ch), .voice_free(voice_free),
        .note_on(note_on), .note_off(note_off), .note(note), .keys_on(keys_on),
        .active_keys(active_keys), .ctrl_cmd(ctrl_cmd), .prg_ch_cmd(prg_ch_cmd),
        .pitch_cmd(pitch_cmd), .cmd(cmd)
    );

    always #50 reg_clk = ~reg_clk;                          // 10 MHz

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic clear_expect();
        exp_on    = 1'b0;
        exp_off   = 1'b0;
        exp_ctrl  = 1'b0;
        exp_prog  = 1'b0;
        exp_pitch = 1'b0;
    endtask

    // note stack and controller rules for one complete message
    task automatic apply_event(input logic [2:0] ty, input logic [6:0] d1, input logic [6:0] d2);
        int hit;
        int slot;
        hit  = -1;
        slot = -1;
        for (int i = 0; i < VOICES; i++) begin
            if (hit < 0 && m_keys[i] && m_tab[i] == d1)
                hit = i;
            if (slot < 0 && voice_free[i] && !m_keys[i])
                slot = i;                                   // lowest free voice
        end
        exp_d1 = d1;
        exp_d2 = d2;
        exp_key = d1;
        exp_vel = d2;
        if (ty == ST_NOTE_ON && d2 != 7'd0) begin
            if (hit < 0 && slot >= 0) begin                 // held key or full stack drops it
                m_keys[slot] = 1'b1;
                m_tab[slot]  = d1;
                exp_on  = 1'b1;
                exp_adr = V_WIDTH'(slot);
            end
        end else if (ty == ST_NOTE_ON || ty == ST_NOTE_OFF) begin
            if (hit >= 0) begin
                m_keys[hit] = 1'b0;
                exp_off = 1'b1;
                exp_adr = V_WIDTH'(hit);
            end
        end else if (ty == ST_CTRL)
            exp_ctrl = 1'b1;
        else if (ty == ST_PROG)
            exp_prog = 1'b1;
        else if (ty == ST_PITCH)
            exp_pitch = 1'b1;
    endtask

    // running status and channel filter
    task automatic model_byte(input logic [7:0] b);
        if (b >= 8'hF8) begin
            // real-time, no effect
        end else if (b >= 8'hF0)
            m_valid = 1'b0;                                 // system byte cancels
        else if (b[7]) begin
            m_valid = 1'b1;
            m_type  = b[6:4];
            m_ch    = b[3:0];
            m_cnt   = 1'b0;
        end else if (m_valid && m_ch == midi_ch) begin
            if (m_type == ST_PROG)
                apply_event(m_type, b[6:0], 7'd0);
            else if (!m_cnt) begin
                m_d1  = b[6:0];
                m_cnt = 1'b1;
            end else begin
                m_cnt = 1'b0;
                apply_event(m_type, m_d1, b[6:0]);
            end
        end
    endtask

    task automatic check_idle();
        compare_value("pulses between bytes",
                      {note_on, note_off, ctrl_cmd, prg_ch_cmd, pitch_cmd}, 32'd0);
    endtask

    task automatic check_outputs();
        compare_value("note_on", note_on, exp_on);
        compare_value("note_off", note_off, exp_off);
        compare_value("ctrl_cmd", ctrl_cmd, exp_ctrl);
        compare_value("prg_ch_cmd", prg_ch_cmd, exp_prog);
        compare_value("pitch_cmd", pitch_cmd, exp_pitch);
        compare_value("keys_on", keys_on, m_keys);
        compare_value("active_keys", active_keys, $countones(m_keys));
        if (exp_on || exp_off) begin
            compare_value("note.key_adr", note.key_adr, exp_adr);
            compare_value("note.key_val", note.key_val, {1'b0, exp_key});
        end
        if (exp_on)
            compare_value("note.vel_on", note.vel_on, {1'b0, exp_vel});
        if (exp_off)
            compare_value("note.vel_off", note.vel_off, {1'b0, exp_vel});
        if (exp_ctrl) begin
            compare_value("cmd.ctrl_num", cmd.ctrl_num, exp_d1);
            compare_value("cmd.ctrl_val", cmd.ctrl_val, exp_d2);
        end
        if (exp_prog)
            compare_value("cmd.prg_num", cmd.prg_num, exp_d1);
        if (exp_pitch)
            compare_value("cmd.pitch", cmd.pitch, {exp_d2, exp_d1});   // full 14 bits
    endtask

    // one processor write, result due 3 edges after the write is sampled
    task automatic send_byte(input logic [2:0] addr, input logic [7:0] b);
        clear_expect();
        if (addr == 3'd0)
            model_byte(b);                                  // other addresses ignored
        socmidi_addr    = addr;
        socmidi_data_in = b;
        socmidi_write   = 1'b1;
        @(negedge reg_clk);
        socmidi_write = 1'b0;
        check_idle();
        @(negedge reg_clk);
        check_idle();
        @(negedge reg_clk);
        check_outputs();
    endtask

    function automatic logic [2:0] pick_status_type();
        case ($urandom % 7)
            0:       return ST_NOTE_OFF;
            1, 2, 3: return ST_NOTE_ON;                     // weighted to fill the stack
            4:       return ST_CTRL;
            5:       return ST_PROG;
            default: return ST_PITCH;
        endcase
    endfunction

    function automatic logic [6:0] random_data(input logic [2:0] ty, input int idx);
        if (ty == ST_NOTE_ON || ty == ST_NOTE_OFF) begin
            if (idx == 0)
                return 7'(60 + $urandom % 12);              // narrow key range, many hits
            return ($urandom % 4 == 0) ? 7'd0 : 7'($urandom % 128);
        end
        return 7'($urandom % 128);
    endfunction

    task automatic send_data(input logic [2:0] ty);
        for (int i = 0; i < ((ty == ST_PROG) ? 1 : 2); i++) begin
            if ($urandom % 8 == 0)
                send_byte(3'd0, 8'(8'hF8 + $urandom % 8));  // real-time inside message
            send_byte(3'd0, {1'b0, random_data(ty, i)});
        end
    endtask

    task automatic random_message();
        int r;
        logic [2:0] ty;
        logic [3:0] ch;
        r = $urandom % 16;
        if (r < 9) begin
            ty = pick_status_type();
            ch = ($urandom % 6 == 0) ? 4'(midi_ch + 1 + $urandom % 15) : midi_ch;
            send_byte(3'd0, {1'b1, ty, ch});
            send_data(ty);
        end else if (r < 12)
            send_data(m_type);                              // running status continuation
        else if (r == 12) begin
            send_byte(3'd0, 8'(8'hF0 + $urandom % 8));
            send_byte(3'd0, 8'($urandom % 128));            // dropped
        end else if (r == 13)
            send_byte(3'd0, 8'(8'hF8 + $urandom % 8));
        else if (r == 14)
            send_byte(3'(1 + $urandom % 7), 8'($urandom));  // wrong register
        else begin
            case ($urandom % 4)
                0:       voice_free = '0;
                1:       voice_free = VOICES'($urandom);
                default: voice_free = '1;
            endcase
        end
    endtask

    task automatic release_held();
        for (int i = 0; i < VOICES; i++) begin
            if (m_keys[i]) begin
                send_byte(3'd0, {4'h8, midi_ch});
                send_byte(3'd0, {1'b0, m_tab[i]});
                send_byte(3'd0, 8'd64);
            end
        end
    endtask

    // one 8N1 frame on midi_rxd, then wait for its result
    task automatic serial_byte(input logic [7:0] b);
        logic expect_pulse;
        logic seen;
        int   limit;
        clear_expect();
        model_byte(b);
        expect_pulse = exp_on | exp_off | exp_ctrl | exp_prog | exp_pitch;
        midi_rxd = 1'b0;                                    // start bit
        repeat (CLKS_PER_BIT) @(negedge reg_clk);
        for (int i = 0; i < 8; i++) begin
            midi_rxd = b[i];
            repeat (CLKS_PER_BIT) @(negedge reg_clk);
        end
        midi_rxd = 1'b1;                                    // stop bit and idle
        seen  = 1'b0;
        limit = expect_pulse ? 20 * CLKS_PER_BIT : CLKS_PER_BIT + 8;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge reg_clk);
            if (note_on || note_off || ctrl_cmd || prg_ch_cmd || pitch_cmd)
                seen = 1'b1;
        end
        if (expect_pulse && !seen) begin
            errors++;
            $display("timeout: no output pulse within 20 bit times after serial byte %02h", b);
        end else
            check_outputs();
        if (seen)
            repeat (CLKS_PER_BIT) @(negedge reg_clk);
    endtask

    task automatic serial_phase();
        logic [6:0] k;
        k = 7'(48 + $urandom % 24);
        serial_byte({4'h9, midi_ch});
        serial_byte({1'b0, k});
        serial_byte(8'(1 + $urandom % 127));
        serial_byte({1'b0, 7'(k + 7'd4)});                  // running status
        serial_byte(8'd80);
        serial_byte({1'b0, k});
        serial_byte(8'd0);                                  // vel 0 release
        serial_byte({4'hB, midi_ch});
        serial_byte(8'($urandom % 128));
        serial_byte(8'($urandom % 128));
        serial_byte({4'hC, midi_ch});
        serial_byte(8'($urandom % 128));
        serial_byte({4'hE, midi_ch});
        serial_byte(8'($urandom % 128));
        serial_byte(8'($urandom % 128));
        serial_byte({4'h9, 4'(midi_ch + 4'd1)});            // foreign channel
        serial_byte({1'b0, k});
        serial_byte(8'd90);
    endtask

    initial begin
        void'($urandom(32'h31f9));
        rst_n           = 1'b0;
        socmidi_addr    = 3'd0;
        socmidi_data_in = 8'h00;
        socmidi_write   = 1'b0;
        midi_rxd        = 1'b1;                             // idle line
        uart_usb_sel    = 1'b0;                             // processor path
        midi_ch         = 4'd3;
        voice_free      = '1;
        m_valid = 1'b0;
        m_type  = ST_NOTE_OFF;
        m_ch    = 4'd0;
        m_cnt   = 1'b0;
        m_d1    = 7'd0;
        m_keys  = '0;
        repeat (5) @(negedge reg_clk);
        rst_n = 1'b1;
        @(negedge reg_clk);
        clear_expect();
        check_outputs();                                    // reset state
        for (int n = 0; n < 1500; n++)
            random_message();
        release_held();
        voice_free      = '1;
        uart_usb_sel    = 1'b1;
        socmidi_addr    = 3'd0;
        socmidi_data_in = 8'hF0;                            // would cancel status if taken
        socmidi_write   = 1'b1;
        repeat (4) @(negedge reg_clk);
        serial_phase();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/midi_pkg.sv
source/voice_pkg.sv
source/midi_uart_rx.sv
source/midi_in_select.sv
source/midi_parser.sv
source/note_stack.sv
source/controller_cmd.sv
source/synth_controller.sv
tests/tb_synth_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_synth_controller
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
